// ==== files.f ====
xfcp_pkg.sv
wb_pkg.sv
wb_ram.sv
xfcp_req_decode.sv
xfcp_wb_exec.sv
xfcp_resp_build.sv
xfcp_core.sv
tb_xfcp_core.sv

// ==== Makefile ====
TOP = tb_xfcp_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

# The run fails unless the log holds the pass line
sim:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_xfcp_core.sv ====
`timescale 1ns/1ps

module tb_xfcp_core
    import xfcp_pkg::*;
    import wb_pkg::*;
();

    typedef wb_data_t   word_q_t[$];
    typedef xfcp_byte_t byte_q_t[$];

    localparam int LCG_SEED   = 24;
    localparam int TEST_COUNT = 6;
    // Longest test sits through 250 quiet cycles
    localparam int TEST_NS    = 8000;

    logic       clk = 1'b0;
    logic       rst_n_i;
    xfcp_byte_t s_tdata_i;
    logic       s_tvalid_i;
    logic       s_tlast_i;
    logic       s_tready_o;
    xfcp_byte_t m_tdata_o;
    logic       m_tvalid_o;
    logic       m_tlast_o;
    logic       m_tready_i;

    logic [31:0] lcg_state = LCG_SEED;

    // Expected RAM contents, one array per route
    wb_data_t model_mem [RAM_COUNT][256];

    xfcp_core xfcp_core_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tlast_i  (s_tlast_i),
        .s_tready_o (s_tready_o),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tlast_o  (m_tlast_o),
        .m_tready_i (m_tready_i)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    initial begin
        #(TEST_COUNT * TEST_NS);
        stop_run("Watchdog expired before all tests finished");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_q_t random_words(input int n);
        word_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(lcg_next());
        end
        return q;
    endfunction

    task automatic check_byte(input string name, input xfcp_byte_t exp, input xfcp_byte_t got);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t: %s expected 0x%h, got 0x%h",
                               $time, name, exp, got));
        end
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t got);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t: %s expected 0x%h, got 0x%h",
                               $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t: %s expected %b, got %b",
                               $time, name, exp, got));
        end
    endtask

    // One byte per transfer, last marker on the final byte
    task automatic send_bytes(input byte_q_t pkt);
        logic taken;
        for (int i = 0; i < pkt.size(); i++) begin
            @(negedge clk);
            s_tdata_i  = pkt[i];
            s_tvalid_i = 1'b1;
            s_tlast_i  = (i == pkt.size() - 1);
            taken      = 1'b0;
            while (!taken) begin
                taken = s_tready_o;
                @(posedge clk);
                if (!taken) begin
                    @(negedge clk);
                end
            end
        end
        @(negedge clk);
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
    endtask

    task automatic send_request(input xfcp_byte_t route, input xfcp_byte_t cmd,
                                input xfcp_byte_t addr, input xfcp_byte_t count,
                                input word_q_t words);
        byte_q_t pkt;
        pkt.push_back(route);
        pkt.push_back(cmd);
        pkt.push_back(addr);
        pkt.push_back(count);
        foreach (words[i]) begin
            for (int k = 0; k < WB_BYTES; k++) begin
                pkt.push_back(words[i][8*k +: 8]);
            end
        end
        send_bytes(pkt);
    endtask

    task automatic recv_response(input xfcp_byte_t route, input xfcp_byte_t cmd,
                                 input xfcp_byte_t addr, input xfcp_byte_t count,
                                 input word_q_t words, input logic random_ready);
        byte_q_t     hdr;
        int          total;
        int          idx;
        int          idle;
        int          pos;
        logic [31:0] r;
        wb_data_t    word;
        hdr.push_back(route);
        hdr.push_back(cmd);
        hdr.push_back(addr);
        hdr.push_back(count);
        total = XFCP_HDR_BYTES + WB_BYTES * words.size();
        idx   = 0;
        idle  = 0;
        word  = '0;
        while (idx < total) begin
            @(negedge clk);
            r = lcg_next();
            m_tready_i = random_ready ? (r[17:16] != 2'b00) : 1'b1;
            if (!m_tvalid_o) begin
                idle++;
                if (idle > 1000) begin
                    stop_run("No response byte arrived within 1000 cycles");
                end
            end else if (m_tready_i) begin
                check_flag("m_tlast_o", (idx == total - 1), m_tlast_o);
                if (idx < XFCP_HDR_BYTES) begin
                    check_byte("m_tdata_o", hdr[idx], m_tdata_o);
                end else begin
                    // Bytes come least significant first
                    pos  = idx - XFCP_HDR_BYTES;
                    word = {m_tdata_o, word[WB_DATA_W-1:8]};
                    if (pos % WB_BYTES == WB_BYTES - 1) begin
                        check_word($sformatf("read word %0d", pos / WB_BYTES),
                                   words[pos / WB_BYTES], word);
                    end
                end
                idx++;
            end
        end
    endtask

    task automatic write_block(input xfcp_byte_t route, input xfcp_byte_t addr,
                               input word_q_t words);
        word_q_t    none;
        xfcp_byte_t count;
        count = xfcp_byte_t'(words.size());
        send_request(route, XFCP_CMD_WRITE, addr, count, words);
        recv_response(route, XFCP_CMD_WRITE + 8'd1, addr, count, none, 1'b0);
        foreach (words[i]) begin
            model_mem[route[0]][8'(addr + i)] = words[i];
        end
    endtask

    task automatic read_block(input xfcp_byte_t route, input xfcp_byte_t addr,
                              input xfcp_byte_t count, input logic random_ready);
        word_q_t none;
        word_q_t exp_words;
        for (int i = 0; i < int'(count); i++) begin
            exp_words.push_back(model_mem[route[0]][8'(addr + i)]);
        end
        send_request(route, XFCP_CMD_READ, addr, count, none);
        recv_response(route, XFCP_CMD_READ + 8'd1, addr, count, exp_words, random_ready);
    endtask

    task automatic watch_quiet(input int cycles);
        m_tready_i = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_flag("m_tvalid_o", 1'b0, m_tvalid_o);
        end
    endtask

    task automatic test_write_read();
        write_block(8'd0, 8'h10, random_words(4));
        read_block(8'd0, 8'h10, 8'd4, 1'b0);
    endtask

    task automatic test_two_rams();
        word_q_t a;
        word_q_t b;
        a = random_words(1);
        b.push_back(~a[0]);
        write_block(8'd0, 8'h40, a);
        write_block(8'd1, 8'h40, b);
        read_block(8'd0, 8'h40, 8'd1, 1'b0);
        read_block(8'd1, 8'h40, 8'd1, 1'b0);
    endtask

    task automatic test_read_backpressure();
        write_block(8'd1, 8'h80, random_words(16));
        read_block(8'd1, 8'h80, 8'd16, 1'b1);
    endtask

    task automatic test_bad_requests();
        byte_q_t pkt;
        word_q_t none;
        // Unknown command whose data word reads like a valid read header
        pkt.push_back(8'd0);
        pkt.push_back(8'h55);
        pkt.push_back(8'h10);
        pkt.push_back(8'd1);
        pkt.push_back(8'd0);
        pkt.push_back(XFCP_CMD_READ);
        pkt.push_back(8'h10);
        pkt.push_back(8'd1);
        send_bytes(pkt);
        watch_quiet(50);
        send_request(8'd2, XFCP_CMD_READ, 8'h10, 8'd1, none);
        watch_quiet(200);
        read_block(8'd0, 8'h10, 8'd4, 1'b0);
    endtask

    task automatic test_wrap_and_empty();
        word_q_t none;
        write_block(8'd0, 8'hFE, random_words(4));
        read_block(8'd0, 8'h00, 8'd2, 1'b0);
        read_block(8'd0, 8'hFE, 8'd4, 1'b0);
        // Count of zero gives a bare header both ways
        read_block(8'd0, 8'h20, 8'd0, 1'b0);
        write_block(8'd0, 8'h20, none);
    endtask

    task automatic test_early_last();
        word_q_t  w;
        byte_q_t  pkt;
        wb_data_t fresh;
        w = random_words(2);
        write_block(8'd1, 8'h30, w);
        fresh = ~w[0];
        pkt.push_back(8'd1);
        pkt.push_back(XFCP_CMD_WRITE);
        pkt.push_back(8'h30);
        pkt.push_back(8'd2);
        for (int k = 0; k < WB_BYTES; k++) begin
            pkt.push_back(fresh[8*k +: 8]);
        end
        // Second word cut after two bytes
        pkt.push_back(8'hA5);
        pkt.push_back(8'h5A);
        send_bytes(pkt);
        watch_quiet(50);
        model_mem[1][8'h30] = fresh;
        read_block(8'd1, 8'h30, 8'd2, 1'b0);
    endtask

    initial begin
        rst_n_i    = 1'b0;
        s_tdata_i  = '0;
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
        m_tready_i = 1'b1;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        check_flag("s_tready_o", 1'b1, s_tready_o);
        check_flag("m_tvalid_o", 1'b0, m_tvalid_o);

        test_write_read();
        test_two_rams();
        test_read_backpressure();
        test_bad_requests();
        test_wrap_and_empty();
        test_early_last();

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== xfcp_core.sv ====
`timescale 1ns/1ps

module xfcp_core
    import xfcp_pkg::*;
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  xfcp_byte_t s_tdata_i,
    input  logic       s_tvalid_i,
    input  logic       s_tlast_i,
    output logic       s_tready_o,
    output xfcp_byte_t m_tdata_o,
    output logic       m_tvalid_o,
    output logic       m_tlast_o,
    input  logic       m_tready_i
);

    // Decode to execute
    logic      cmd_valid;
    xfcp_hdr_u hdr;
    logic      wr_valid;
    wb_data_t  wr_data;
    logic      wr_ready;
    logic      abort;

    // Execute to result
    logic      resp_hdr_valid;
    xfcp_hdr_u resp_hdr;
    logic      rd_valid;
    wb_data_t  rd_data;
    logic      resp_ready;

    // Wishbone, one lane per RAM
    wb_addr_t [RAM_COUNT-1:0] wb_adr;
    wb_data_t [RAM_COUNT-1:0] wb_dat_w;
    wb_data_t [RAM_COUNT-1:0] wb_dat_r;
    logic [RAM_COUNT-1:0]     wb_we;
    logic [RAM_COUNT-1:0]     wb_stb;
    logic [RAM_COUNT-1:0]     wb_cyc;
    logic [RAM_COUNT-1:0]     wb_ack;

    xfcp_req_decode req_decode_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s_tdata_i   (s_tdata_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tlast_i   (s_tlast_i),
        .s_tready_o  (s_tready_o),
        .cmd_valid_o (cmd_valid),
        .hdr_o       (hdr),
        .wr_valid_o  (wr_valid),
        .wr_data_o   (wr_data),
        .wr_ready_i  (wr_ready),
        .abort_o     (abort)
    );

    xfcp_wb_exec wb_exec_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cmd_valid_i      (cmd_valid),
        .hdr_i            (hdr),
        .wr_valid_i       (wr_valid),
        .wr_data_i        (wr_data),
        .wr_ready_o       (wr_ready),
        .abort_i          (abort),
        .resp_hdr_valid_o (resp_hdr_valid),
        .resp_hdr_o       (resp_hdr),
        .rd_valid_o       (rd_valid),
        .rd_data_o        (rd_data),
        .resp_ready_i     (resp_ready),
        .wb_adr_o         (wb_adr),
        .wb_dat_o         (wb_dat_w),
        .wb_we_o          (wb_we),
        .wb_stb_o         (wb_stb),
        .wb_cyc_o         (wb_cyc),
        .wb_dat_i         (wb_dat_r),
        .wb_ack_i         (wb_ack)
    );

    for (genvar i = 0; i < RAM_COUNT; i++) begin : g_ram
        wb_ram ram_i (
            .clk   (clk),
            .adr_i (wb_adr[i]),
            .dat_i (wb_dat_w[i]),
            .we_i  (wb_we[i]),
            .stb_i (wb_stb[i]),
            .cyc_i (wb_cyc[i]),
            .dat_o (wb_dat_r[i]),
            .ack_o (wb_ack[i])
        );
    end

    xfcp_resp_build resp_build_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .resp_hdr_valid_i (resp_hdr_valid),
        .resp_hdr_i       (resp_hdr),
        .rd_valid_i       (rd_valid),
        .rd_data_i        (rd_data),
        .resp_ready_o     (resp_ready),
        .m_tdata_o        (m_tdata_o),
        .m_tvalid_o       (m_tvalid_o),
        .m_tlast_o        (m_tlast_o),
        .m_tready_i       (m_tready_i)
    );

endmodule

// ==== xfcp_resp_build.sv ====
`timescale 1ns/1ps

module xfcp_resp_build
    import xfcp_pkg::*;
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       resp_hdr_valid_i,
    input  xfcp_hdr_u  resp_hdr_i,
    input  logic       rd_valid_i,
    input  wb_data_t   rd_data_i,
    output logic       resp_ready_o,
    output xfcp_byte_t m_tdata_o,
    output logic       m_tvalid_o,
    output logic       m_tlast_o,
    input  logic       m_tready_i
);

    enum logic [1:0] {R_IDLE, R_HDR, R_WAIT, R_DATA} state;

    xfcp_hdr_u  hdr_q;
    wb_data_t   word_q;
    logic [1:0] byte_idx;
    xfcp_byte_t word_cnt;
    logic       hdr_done;
    logic       word_done;
    logic       final_word;
    logic       hdr_only;

    assign hdr_done   = (byte_idx == 2'(XFCP_HDR_BYTES - 1));
    assign word_done  = (byte_idx == 2'(WB_BYTES - 1));
    assign final_word = (word_cnt == hdr_q.f.count - 8'd1);

    // Only a read with a nonzero count carries data words
    assign hdr_only = (hdr_q.f.cmd != XFCP_CMD_READ + 8'd1) || (hdr_q.f.count == 8'd0);

    // Ready only while no byte is left to send
    assign resp_ready_o = (state == R_IDLE) || (state == R_WAIT);
    assign m_tvalid_o   = (state == R_HDR) || (state == R_DATA);

    always_comb begin
        if (state == R_HDR) begin
            // Route byte goes out first
            m_tdata_o = hdr_q.b[2'(XFCP_HDR_BYTES - 1) - byte_idx];
            m_tlast_o = hdr_done && hdr_only;
        end else begin
            m_tdata_o = word_q[8*byte_idx +: 8];
            m_tlast_o = (state == R_DATA) && word_done && final_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= R_IDLE;
            byte_idx <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (resp_hdr_valid_i) begin
                        state    <= R_HDR;
                        byte_idx <= '0;
                        word_cnt <= '0;
                    end
                end
                R_HDR: begin
                    if (m_tready_i) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (hdr_done) begin
                            state <= hdr_only ? R_IDLE : R_WAIT;
                        end
                    end
                end
                R_WAIT: begin
                    if (rd_valid_i) begin
                        state    <= R_DATA;
                        byte_idx <= '0;
                    end
                end
                default: begin
                    if (m_tready_i) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (word_done) begin
                            word_cnt <= word_cnt + 8'd1;
                            state    <= final_word ? R_IDLE : R_WAIT;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && resp_hdr_valid_i) begin
            hdr_q <= resp_hdr_i;
        end
        if (state == R_WAIT && rd_valid_i) begin
            word_q <= rd_data_i;
        end
    end

endmodule

// ==== xfcp_wb_exec.sv ====
`timescale 1ns/1ps

module xfcp_wb_exec
    import xfcp_pkg::*;
    import wb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     cmd_valid_i,
    input  xfcp_hdr_u                hdr_i,
    input  logic                     wr_valid_i,
    input  wb_data_t                 wr_data_i,
    output logic                     wr_ready_o,
    input  logic                     abort_i,
    output logic                     resp_hdr_valid_o,
    output xfcp_hdr_u                resp_hdr_o,
    output logic                     rd_valid_o,
    output wb_data_t                 rd_data_o,
    input  logic                     resp_ready_i,
    output wb_addr_t [RAM_COUNT-1:0] wb_adr_o,
    output wb_data_t [RAM_COUNT-1:0] wb_dat_o,
    output logic [RAM_COUNT-1:0]     wb_we_o,
    output logic [RAM_COUNT-1:0]     wb_stb_o,
    output logic [RAM_COUNT-1:0]     wb_cyc_o,
    input  wb_data_t [RAM_COUNT-1:0] wb_dat_i,
    input  logic [RAM_COUNT-1:0]     wb_ack_i
);

    enum logic [2:0] {E_IDLE, E_WR_WAIT, E_BUS, E_RD_OUT, E_HDR_OUT} state;

    wb_addr_t   addr_q;
    xfcp_byte_t remain_q;
    ram_sel_t   sel_q;
    logic       we_q;
    logic       abort_q;
    wb_data_t   dat_w_q;
    logic       ack;

    assign ack = wb_ack_i[sel_q];

    // Idle also reads as ready so that decode can release the next header
    assign wr_ready_o       = (state == E_IDLE) || (state == E_WR_WAIT);
    assign resp_hdr_valid_o = (state == E_HDR_OUT);
    assign rd_valid_o       = (state == E_RD_OUT);

    always_comb begin
        for (int i = 0; i < RAM_COUNT; i++) begin
            wb_adr_o[i] = addr_q;
            wb_dat_o[i] = dat_w_q;
            wb_we_o[i]  = we_q;
            // Only the routed RAM sees a bus cycle
            wb_stb_o[i] = (state == E_BUS) && (sel_q == ram_sel_t'(i));
            wb_cyc_o[i] = (state == E_BUS) && (sel_q == ram_sel_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= E_IDLE;
            addr_q   <= '0;
            remain_q <= '0;
            sel_q    <= '0;
            we_q     <= 1'b0;
            abort_q  <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    abort_q <= 1'b0;
                    if (cmd_valid_i) begin
                        addr_q   <= hdr_i.f.addr;
                        remain_q <= hdr_i.f.count;
                        sel_q    <= ram_sel_t'(hdr_i.f.route);
                        we_q     <= (hdr_i.f.cmd == XFCP_CMD_WRITE);
                        // Reads answer the header first, writes after the last ack
                        if (hdr_i.f.cmd == XFCP_CMD_WRITE && hdr_i.f.count != 8'd0) begin
                            state <= E_WR_WAIT;
                        end else begin
                            state <= E_HDR_OUT;
                        end
                    end
                end
                E_WR_WAIT: begin
                    if (abort_i) begin
                        state <= E_IDLE;
                    end else if (wr_valid_i) begin
                        state <= E_BUS;
                    end
                end
                E_BUS: begin
                    if (abort_i) begin
                        abort_q <= 1'b1;
                    end
                    if (ack && !we_q) begin
                        state <= E_RD_OUT;
                    end else if (ack) begin
                        addr_q   <= addr_q + 8'd1;
                        remain_q <= remain_q - 8'd1;
                        // Finish the current word, then drop the packet
                        if (abort_q || abort_i) begin
                            state <= E_IDLE;
                        end else if (remain_q == 8'd1) begin
                            state <= E_HDR_OUT;
                        end else begin
                            state <= E_WR_WAIT;
                        end
                    end
                end
                E_RD_OUT: begin
                    if (resp_ready_i) begin
                        addr_q   <= addr_q + 8'd1;
                        remain_q <= remain_q - 8'd1;
                        state    <= (remain_q == 8'd1) ? E_IDLE : E_BUS;
                    end
                end
                default: begin
                    if (resp_ready_i) begin
                        state <= (we_q || remain_q == 8'd0) ? E_IDLE : E_BUS;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_IDLE && cmd_valid_i) begin
            resp_hdr_o       <= hdr_i;
            resp_hdr_o.f.cmd <= hdr_i.f.cmd + 8'd1;
        end
        if (state == E_WR_WAIT && wr_valid_i) begin
            dat_w_q <= wr_data_i;
        end
        if (state == E_BUS && ack) begin
            rd_data_o <= wb_dat_i[sel_q];
        end
    end

endmodule

// ==== xfcp_req_decode.sv ====
`timescale 1ns/1ps

module xfcp_req_decode
    import xfcp_pkg::*;
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  xfcp_byte_t s_tdata_i,
    input  logic       s_tvalid_i,
    input  logic       s_tlast_i,
    output logic       s_tready_o,
    output logic       cmd_valid_o,
    output xfcp_hdr_u  hdr_o,
    output logic       wr_valid_o,
    output wb_data_t   wr_data_o,
    input  logic       wr_ready_i,
    output logic       abort_o
);

    enum logic [1:0] {D_HDR, D_WR, D_DRAIN} state;

    logic [1:0] hdr_idx;
    logic [1:0] byte_idx;
    xfcp_byte_t words_left;
    wb_data_t   word_q;
    wb_data_t   word_next;
    xfcp_hdr_u  hdr_next;
    logic       accept;
    logic       hdr_last;
    logic       word_last;
    logic       is_read;
    logic       hdr_ok;
    logic       needs_data;

    assign accept    = s_tvalid_i && s_tready_o;
    assign hdr_last  = (hdr_idx == 2'(XFCP_HDR_BYTES - 1));
    assign word_last = (byte_idx == 2'(WB_BYTES - 1));

    // Data bytes arrive least significant first
    assign word_next = {s_tdata_i, word_q[WB_DATA_W-1:8]};

    always_comb begin
        hdr_next.b = {hdr_o.b[XFCP_HDR_BYTES-2:0], s_tdata_i};
    end

    assign is_read    = (hdr_next.f.cmd == XFCP_CMD_READ);
    assign hdr_ok     = (hdr_next.f.route < xfcp_byte_t'(RAM_COUNT)) &&
                        (is_read || hdr_next.f.cmd == XFCP_CMD_WRITE);
    assign needs_data = !is_read && (hdr_next.f.count != 8'd0);

    always_comb begin
        case (state)
            // Last header byte waits until execute is idle
            D_HDR:   s_tready_o = !hdr_last || (wr_ready_i && !wr_valid_o && !abort_o);
            D_WR:    s_tready_o = !(word_last && wr_valid_o && !wr_ready_i);
            default: s_tready_o = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= D_HDR;
            hdr_idx     <= '0;
            byte_idx    <= '0;
            words_left  <= '0;
            cmd_valid_o <= 1'b0;
            wr_valid_o  <= 1'b0;
            abort_o     <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            abort_o     <= 1'b0;
            if (wr_valid_o && wr_ready_i) begin
                wr_valid_o <= 1'b0;
            end
            if (accept) begin
                case (state)
                    D_HDR: begin
                        hdr_idx <= hdr_idx + 2'd1;
                        if (s_tlast_i && !hdr_last) begin
                            // Header cut short
                            hdr_idx <= '0;
                        end else if (hdr_last) begin
                            byte_idx   <= '0;
                            words_left <= hdr_next.f.count;
                            // A write whose data never comes is not run
                            if (hdr_ok && !(s_tlast_i && needs_data)) begin
                                cmd_valid_o <= 1'b1;
                            end
                            if (!s_tlast_i) begin
                                state <= (hdr_ok && needs_data) ? D_WR : D_DRAIN;
                            end
                        end
                    end
                    D_WR: begin
                        byte_idx <= byte_idx + 2'd1;
                        if (word_last && words_left == 8'd1) begin
                            wr_valid_o <= 1'b1;
                            state      <= s_tlast_i ? D_HDR : D_DRAIN;
                        end else if (s_tlast_i) begin
                            abort_o    <= 1'b1;
                            wr_valid_o <= 1'b0;
                            state      <= D_HDR;
                        end else if (word_last) begin
                            wr_valid_o <= 1'b1;
                            words_left <= words_left - 8'd1;
                        end
                    end
                    default: begin
                        if (s_tlast_i) begin
                            state <= D_HDR;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == D_HDR) begin
            hdr_o <= hdr_next;
        end
        if (accept && state == D_WR) begin
            word_q <= word_next;
            if (word_last) begin
                wr_data_o <= word_next;
            end
        end
    end

endmodule

// ==== wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram
    import wb_pkg::*;
(
    input  logic     clk,
    input  wb_addr_t adr_i,
    input  wb_data_t dat_i,
    input  logic     we_i,
    input  logic     stb_i,
    input  logic     cyc_i,
    output wb_data_t dat_o,
    output logic     ack_o
);

    wb_data_t mem [2**WB_ADDR_W];

    // One access per strobe
    // ack blocks a second access while the master still holds stb
    always_ff @(posedge clk) begin
        ack_o <= 1'b0;
        if (stb_i && cyc_i && !ack_o) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
            ack_o <= 1'b1;
        end
    end

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

    localparam int WB_ADDR_W = 8;
    localparam int WB_DATA_W = 32;
    localparam int WB_BYTES  = 4;

    // Number of RAMs behind the route byte
    localparam int RAM_COUNT = 2;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // Selects RAM 0 or RAM 1
    typedef logic [$clog2(RAM_COUNT)-1:0] ram_sel_t;

endpackage

// ==== xfcp_pkg.sv ====
package xfcp_pkg;

    // One byte on the request or response stream
    typedef logic [7:0] xfcp_byte_t;

    // Request command codes
    // The response code is the request code plus one
    localparam xfcp_byte_t XFCP_CMD_READ  = 8'h10;
    localparam xfcp_byte_t XFCP_CMD_WRITE = 8'h12;

    localparam int XFCP_HDR_BYTES = 4;

    // Header fields in arrival order, route first on the wire
    typedef struct packed {
        xfcp_byte_t route;
        xfcp_byte_t cmd;
        xfcp_byte_t addr;
        xfcp_byte_t count;
    } xfcp_hdr_t;

    // Byte view while the header is shifted in or out
    // b[3] holds the route byte and b[0] the count byte
    typedef union packed {
        xfcp_hdr_t                       f;
        xfcp_byte_t [XFCP_HDR_BYTES-1:0] b;
    } xfcp_hdr_u;

endpackage
